// File: zx_mem_mapper.f
+incdir+include
design/zx_pkg.sv
design/z80_cycle_decoder.sv
design/io_port_regs.sv
design/ram_addr_translator.sv
design/zx_mem_mapper.sv
sim/tb_zx_mem_mapper.sv

// File: Makefile
# Verilator build and run for the memory mapper testbench

TOP = tb_zx_mem_mapper

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f zx_mem_mapper.f --top-module $(TOP) -o $(TOP)

# Pass only when the testbench prints its pass line
run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

// File: sim/tb_zx_mem_mapper.sv
//==========================================================
// Testbench for the Spectrum memory mapper
// Drives Z80 bus cycles, models the paging ports and
// checks every RAM request against a reference mapping
//==========================================================
`timescale 1ns/1ns
`include "zx_mapper_cfg.svh"

module tb_zx_mem_mapper
	import zx_pkg::*;
;

	localparam int SEED    = 32'h7a5c_8d56;
	localparam int MEM_CYC = 4;
	localparam int IO_CYC  = 6;
	localparam int RST_CYC = 4;
	localparam int T1_LEN  = RST_CYC + 9 * MEM_CYC;
	localparam int T2_LEN  = 6 * (IO_CYC + 2 * MEM_CYC) + 2 * IO_CYC + MEM_CYC +
		RST_CYC + IO_CYC + MEM_CYC;
	localparam int T3_LEN  = RST_CYC + 4 * (IO_CYC + 5 * MEM_CYC) +
		4 * (2 * IO_CYC + MEM_CYC);
	localparam int T4_LEN  = RST_CYC + 6 * (2 * IO_CYC + 2 * MEM_CYC) +
		RST_CYC + 6 * (2 * IO_CYC + MEM_CYC);
	localparam int T5_LEN  = RST_CYC + 3 * (IO_CYC + MEM_CYC) + 8 * (IO_CYC + MEM_CYC);
	localparam int TIMEOUT = 2 * (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN);

	logic                    clk_sys;
	logic                    reset;
	z80_bus_t                bus;
	machine_e                machine;
	mem_req_t                ram_req;
	logic [`ZX_BORDER_W-1:0] border_color;
	logic                    ear;
	logic                    mic;
	logic                    screen_page;

	// Reference model of the port registers
	machine_e                m_machine;
	logic [7:0]              m_page_reg;
	logic [7:0]              m_plus3;
	logic [7:0]              m_p1024;
	logic [2:0]              m_128k;
	logic [`ZX_BORDER_W-1:0] m_border;
	logic                    m_ear;
	logic                    m_mic;

	// Expected request for the pending check
	logic [`ZX_RAM_ADDR_W-1:0] exp_addr;
	logic [7:0]                exp_data;
	logic                      exp_rd;
	logic                      exp_wr;
	logic                      exp_scr;

	int chk_seq  = 0;
	int chk_done = 0;
	int checks   = 0;
	int errors   = 0;
	int cycles   = 0;

	zx_mem_mapper u_zx_mem_mapper (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.machine      (machine),
		.ram_req      (ram_req),
		.border_color (border_color),
		.ear          (ear),
		.mic          (mic),
		.screen_page  (screen_page)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ======================================================
	// Reference mapping
	// ======================================================
	function automatic logic model_locked();
		if (m_machine == zx48)
			return 1'b1;
		if (m_machine == pentagon1024)
			return m_page_reg[5] & m_p1024[2];
		return m_page_reg[5];
	endfunction

	function automatic void ref_map(input logic [15:0] addr, input logic is_wr,
		output logic [`ZX_RAM_ADDR_W-1:0] ram_addr, output logic wr, output logic scr);
		int         sidx;
		logic [11:0] row;
		logic [5:0]  page;
		logic [3:0]  rom;
		logic        in_rom;
		sidx   = int'(addr[15:14]);
		in_rom = 1'b0;
		page   = '0;
		row    = '0;
		if (m_plus3[0]) begin
			// Slot 0 sits in the lowest three bits of each row
			case (m_plus3[2:1])
				2'd0: row = {3'd3, 3'd2, 3'd1, 3'd0};
				2'd1: row = {3'd7, 3'd6, 3'd5, 3'd4};
				2'd2: row = {3'd3, 3'd6, 3'd5, 3'd4};
				default: row = {3'd3, 3'd6, 3'd7, 3'd4};
			endcase
			page = {3'b000, row[sidx*3 +: 3]};
		end else if (sidx == 0) begin
			in_rom = 1'b1;
		end else if (sidx == 1) begin
			page = 6'd5;
		end else if (sidx == 2) begin
			page = 6'd2;
		end else begin
			page = {m_128k, m_page_reg[2:0]};
		end
		case (m_machine)
			zx48:    rom = 4'b1111;
			plus3:   rom = {2'b10, m_plus3[2], m_page_reg[4]};
			default: rom = {3'b011, m_page_reg[4]};
		endcase
		if (in_rom)
			ram_addr = `ZX_RAM_ADDR_W'({`ZX_ROM_BASE, rom, addr[13:0]});
		else
			ram_addr = `ZX_RAM_ADDR_W'({page, addr[13:0]});
		wr  = is_wr & ~in_rom;
		scr = wr & (page == 6'd5 || page == 6'd7);
	endfunction

	// ======================================================
	// Address generators and bus tasks
	// ======================================================
	function automatic logic [15:0] rand_in_slot(input logic [1:0] s);
		logic [15:0] a;
		a = 16'($urandom);
		a[15:14] = s;
		return a;
	endfunction

	// Paging port address, A14 set so the +3 sees it too
	function automatic logic [15:0] addr_7ffd();
		logic [15:0] a;
		a = 16'($urandom);
		a[15:14] = 2'b01;
		a[1:0] = 2'b01;
		return a;
	endfunction

	function automatic logic [15:0] addr_1ffd();
		logic [15:0] a;
		a = 16'($urandom);
		a[15:12] = 4'b0001;
		a[1:0] = 2'b01;
		return a;
	endfunction

	function automatic logic [15:0] addr_eff7();
		logic [15:0] a;
		a = 16'($urandom);
		a[15:12] = 4'b1110;
		a[3] = 1'b0;
		a[0] = 1'b1;
		return a;
	endfunction

	task automatic apply_reset(input machine_e m);
		@(posedge clk_sys);
		machine <= m;
		reset <= 1'b1;
		bus <= '0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		m_machine  = m;
		m_page_reg = '0;
		m_plus3    = '0;
		m_p1024    = '0;
		m_128k     = '0;
		m_border   = '0;
		m_ear      = 1'b0;
		m_mic      = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		z80_bus_t b;
		logic     hit_fe;
		logic     hit_7ffd;
		logic     hit_1ffd;
		logic     hit_eff7;
		logic     hit_dffd;
		logic     lock;
		b = '0;
		b.addr = a;
		b.data = d;
		b.iorq = 1'b1;
		b.wr = 1'b1;
		hit_fe   = ~a[0];
		hit_7ffd = a[0] & ~a[15] & ~a[1] & (a[14] | (m_machine != plus3));
		hit_1ffd = a[0] & (a[15:12] == 4'b0001) & ~a[1] & (m_machine == plus3);
		hit_eff7 = a[0] & (a[15:12] == 4'b1110) & ~a[3] & (m_machine == pentagon1024);
		hit_dffd = (a == 16'hDFFD) & (m_machine == profi1024);
		lock = model_locked();
		@(posedge clk_sys);
		bus <= b;
		repeat (2) @(posedge clk_sys);
		bus <= '0;
		repeat (3) @(posedge clk_sys);
		if (hit_7ffd && !lock) begin
			m_page_reg = d;
			if (m_machine == pentagon1024 && !m_p1024[2])
				m_128k = {d[5], d[7], d[6]};
		end
		if (hit_1ffd && !lock)
			m_plus3 = d;
		if (hit_eff7)
			m_p1024 = d;
		if (hit_dffd)
			m_128k = d[2:0];
		if (hit_fe) begin
			m_border = d[2:0];
			m_mic    = d[3];
			m_ear    = d[4];
		end
	endtask

	// Holds a memory cycle for four clocks and asks for one check
	task automatic mem_access(input logic [15:0] a, input logic is_wr);
		z80_bus_t b;
		b = '0;
		b.addr = a;
		b.data = 8'($urandom);
		b.mreq = 1'b1;
		b.rd = ~is_wr;
		b.wr = is_wr;
		@(posedge clk_sys);
		bus <= b;
		ref_map(a, is_wr, exp_addr, exp_wr, exp_scr);
		exp_rd = ~is_wr;
		exp_data = b.data;
		// Request is registered one clock after the bus
		@(posedge clk_sys);
		chk_seq = chk_seq + 1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic report_test(input int n, input string name, input int e0, input int c0);
		$display("Test %0d %s: %0d checks, %0d errors", n, name, checks - c0, errors - e0);
	endtask

	// ======================================================
	// Checker, samples away from the clock edge
	// ======================================================
	always @(negedge clk_sys) begin
		if (chk_seq != chk_done) begin
			chk_done = chk_seq;
			checks = checks + 1;
			if (ram_req.addr !== exp_addr) begin
				$display("** Error: ram_req.addr = %h, expected %h", ram_req.addr, exp_addr);
				errors = errors + 1;
			end
			if (ram_req.data !== exp_data) begin
				$display("** Error: ram_req.data = %h, expected %h", ram_req.data, exp_data);
				errors = errors + 1;
			end
			if (ram_req.rd !== exp_rd) begin
				$display("** Error: ram_req.rd = %h, expected %h", ram_req.rd, exp_rd);
				errors = errors + 1;
			end
			if (ram_req.wr !== exp_wr) begin
				$display("** Error: ram_req.wr = %h, expected %h", ram_req.wr, exp_wr);
				errors = errors + 1;
			end
			if (ram_req.screen_we !== exp_scr) begin
				$display("** Error: ram_req.screen_we = %h, expected %h",
					ram_req.screen_we, exp_scr);
				errors = errors + 1;
			end
			if (screen_page !== m_page_reg[3]) begin
				$display("** Error: screen_page = %h, expected %h", screen_page, m_page_reg[3]);
				errors = errors + 1;
			end
			// Border, EAR and MIC together
			if ({border_color, ear, mic} !== {m_border, m_ear, m_mic}) begin
				$display("** Error: {border_color, ear, mic} = %h, expected %h",
					{border_color, ear, mic}, {m_border, m_ear, m_mic});
				errors = errors + 1;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("Test failed");
			$finish;
		end
	end

	// ======================================================
	// Test sequence
	// ======================================================
	initial begin
		int e0;
		int c0;
		int i;
		reset <= 1'b1;
		bus <= '0;
		machine <= zx128;
		void'($urandom(SEED));

		e0 = errors;
		c0 = checks;
		apply_reset(zx128);
		for (i = 0; i < 8; i++)
			mem_access(rand_in_slot(2'(i)), 1'b0);
		mem_access(rand_in_slot(2'd0), 1'b1);
		report_test(1, "zx128 after reset", e0, c0);

		e0 = errors;
		c0 = checks;
		for (i = 0; i < 6; i++) begin
			io_write(addr_7ffd(), 8'($urandom) & 8'hDF);
			mem_access(rand_in_slot(2'd3), 1'b0);
			mem_access(rand_in_slot(2'd0), 1'b0);
		end
		io_write(addr_7ffd(), 8'($urandom) | 8'h20);
		io_write(addr_7ffd(), 8'($urandom) & 8'hDF);
		mem_access(rand_in_slot(2'd3), 1'b0);
		apply_reset(zx128);
		io_write(addr_7ffd(), 8'($urandom) & 8'hDF);
		mem_access(rand_in_slot(2'd3), 1'b0);
		report_test(2, "7FFD paging and lock", e0, c0);

		e0 = errors;
		c0 = checks;
		apply_reset(plus3);
		for (i = 0; i < 4; i++) begin
			io_write(addr_1ffd(), (8'($urandom) & 8'hF8) | {5'b0, 2'(i), 1'b1});
			mem_access(rand_in_slot(2'd0), 1'b0);
			mem_access(rand_in_slot(2'd1), 1'b0);
			mem_access(rand_in_slot(2'd2), 1'b0);
			mem_access(rand_in_slot(2'd3), 1'b0);
			mem_access(rand_in_slot(2'd0), 1'b1);
		end
		for (i = 0; i < 4; i++) begin
			io_write(addr_1ffd(), (8'($urandom) & 8'hFA) | {5'b0, i[1], 2'b00});
			io_write(addr_7ffd(), (8'($urandom) & 8'hCF) | {3'b0, i[0], 4'b0});
			mem_access(rand_in_slot(2'd0), 1'b0);
		end
		report_test(3, "plus3 special paging and ROM", e0, c0);

		e0 = errors;
		c0 = checks;
		apply_reset(pentagon1024);
		// EFF7 bit 2 alternates, so the lock comes and goes
		for (i = 0; i < 6; i++) begin
			io_write(addr_eff7(), (8'($urandom) & 8'hFB) | {5'b0, i[0], 2'b00});
			io_write(addr_7ffd(), 8'($urandom) | 8'h20);
			mem_access(rand_in_slot(2'd3), 1'b0);
			mem_access(rand_in_slot(2'd3), 1'b1);
		end
		apply_reset(profi1024);
		for (i = 0; i < 6; i++) begin
			io_write(16'hDFFD, 8'($urandom));
			io_write(addr_7ffd(), 8'($urandom) & 8'hDF);
			mem_access(rand_in_slot(2'd3), 1'b0);
		end
		report_test(4, "Pentagon and Profi extensions", e0, c0);

		e0 = errors;
		c0 = checks;
		apply_reset(zx128);
		for (i = 0; i < 3; i++) begin
			io_write(16'($urandom) & 16'hFFFE, 8'($urandom));
			mem_access(rand_in_slot(2'd2), 1'b0);
		end
		// Slot 3 lands on page 3 and then page 7
		for (i = 0; i < 8; i++) begin
			io_write(addr_7ffd(), (8'($urandom) & 8'hD8) | 8'(i));
			mem_access(rand_in_slot(2'(i)), 1'b1);
		end
		report_test(5, "ULA port and screen writes", e0, c0);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: design/zx_mem_mapper.sv
//==========================================================
// Spectrum 128K-class memory mapper
// Z80 bus in, paged 25-bit external RAM request out
//==========================================================
`timescale 1ns/1ns
`include "zx_mapper_cfg.svh"

module zx_mem_mapper
	import zx_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  z80_bus_t                bus,
	input  machine_e                machine,
	output mem_req_t                ram_req,
	output logic [`ZX_BORDER_W-1:0] border_color,
	output logic                    ear,
	output logic                    mic,
	output logic                    screen_page
);

	mem_cmd_t    mem_cmd;
	port_write_t port_wr;
	paging_t     paging;
	machine_e    machine_q;

	z80_cycle_decoder u_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.machine_q (machine_q),
		.mem_cmd   (mem_cmd),
		.port_wr   (port_wr)
	);

	io_port_regs u_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.port_wr      (port_wr),
		.paging       (paging),
		.machine_q    (machine_q),
		.border_color (border_color),
		.ear          (ear),
		.mic          (mic),
		.screen_page  (screen_page)
	);

	ram_addr_translator u_xlate (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mem_cmd   (mem_cmd),
		.paging    (paging),
		.machine_q (machine_q),
		.ram_req   (ram_req)
	);

endmodule

// File: design/ram_addr_translator.sv
//==========================================================
// RAM address translator
// Maps the four 16 KB CPU slots onto ROM and RAM pages,
// drops ROM writes and registers the external RAM request
//==========================================================
`timescale 1ns/1ns
`include "zx_mapper_cfg.svh"

module ram_addr_translator
	import zx_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  mem_cmd_t mem_cmd,
	input  paging_t  paging,
	input  machine_e machine_q,
	output mem_req_t ram_req
);

	localparam int PAGE_W = 6;

	logic [1:0]                slot;
	logic [`ZX_BANK_OFS_W-1:0] ofs;
	logic                      special;
	logic                      rom_sel;
	logic [3:0]                rom_page;
	logic [PAGE_W-1:0]         ram_page;
	logic [`ZX_RAM_ADDR_W-1:0] addr_d;
	logic                      wr_d;
	logic                      screen_d;

	logic [`ZX_RAM_ADDR_W-1:0] addr_q;
	logic [`ZX_DATA_W-1:0]     data_q;
	logic                      rd_q;
	logic                      wr_q;
	logic                      screen_q;

	// +3 all-RAM layouts, indexed by 1FFD bits 2..1
	function automatic logic [PAGE_W-1:0] special_page(input logic [1:0] mode,
		input logic [1:0] s);
		logic [PAGE_W-1:0] pg;
		case (mode)
			2'd0: pg = PAGE_W'(s);
			2'd1: pg = PAGE_W'(s) + PAGE_W'(4);
			2'd2: pg = (s == 2'd3) ? PAGE_W'(3) : PAGE_W'(s) + PAGE_W'(4);
			default: begin
				case (s)
					2'd0: pg = PAGE_W'(4);
					2'd1: pg = PAGE_W'(7);
					2'd2: pg = PAGE_W'(6);
					default: pg = PAGE_W'(3);
				endcase
			end
		endcase
		return pg;
	endfunction

	assign slot    = mem_cmd.addr[`ZX_CPU_ADDR_W-1 -: 2];
	assign ofs     = mem_cmd.addr[`ZX_BANK_OFS_W-1:0];
	assign special = paging.page_reg_plus3[`ZX_1FFD_SPECIAL_BIT];

	// ======================================================
	// ROM page select
	// ======================================================
	always_comb begin
		case (machine_q)
			zx48:    rom_page = 4'b1111;
			plus3:   rom_page = {2'b10, paging.page_reg_plus3[`ZX_1FFD_ROM_BIT],
				paging.page_reg[`ZX_7FFD_ROM_BIT]};
			default: rom_page = {3'b011, paging.page_reg[`ZX_7FFD_ROM_BIT]};
		endcase
	end

	// ======================================================
	// Slot to page mapping
	// ======================================================
	always_comb begin
		rom_sel  = 1'b0;
		ram_page = '0;
		if (special) begin
			ram_page = special_page(paging.page_reg_plus3[2:1], slot);
		end else begin
			case (slot)
				2'd0: rom_sel = 1'b1;
				2'd1: ram_page = PAGE_W'(5);
				2'd2: ram_page = PAGE_W'(2);
				default: ram_page = {paging.page_128k, paging.page_reg[2:0]};
			endcase
		end

		if (rom_sel)
			addr_d = `ZX_RAM_ADDR_W'({`ZX_ROM_BASE, rom_page, ofs});
		else
			addr_d = `ZX_RAM_ADDR_W'({ram_page, ofs});

		// ROM slot is read only
		wr_d     = mem_cmd.wr & ~rom_sel;
		screen_d = wr_d & ((ram_page == PAGE_W'(`ZX_SCREEN_BANK_A)) |
			(ram_page == PAGE_W'(`ZX_SCREEN_BANK_B)));
	end

	// Output register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
			screen_q <= 1'b0;
		end else begin
			rd_q     <= mem_cmd.rd;
			wr_q     <= wr_d;
			screen_q <= screen_d;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= addr_d;
		data_q <= mem_cmd.data;
	end

	assign ram_req = '{
		addr:      addr_q,
		data:      data_q,
		rd:        rd_q,
		wr:        wr_q,
		screen_we: screen_q
	};

	// Bus strobes never ask for a read and a write in one cycle
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ram_req.rd && ram_req.wr));

endmodule

// File: design/io_port_regs.sv
//==========================================================
// I/O port registers
// 7FFD, 1FFD, EFF7 and DFFD paging state, the ULA port FE
// and the machine type latched while reset is held
//==========================================================
`timescale 1ns/1ns
`include "zx_mapper_cfg.svh"

module io_port_regs
	import zx_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  machine_e                machine,
	input  port_write_t             port_wr,
	output paging_t                 paging,
	output machine_e                machine_q,
	output logic [`ZX_BORDER_W-1:0] border_color,
	output logic                    ear,
	output logic                    mic,
	output logic                    screen_page
);

	logic [`ZX_DATA_W-1:0] page_reg;
	logic [`ZX_DATA_W-1:0] page_reg_plus3;
	logic [`ZX_DATA_W-1:0] page_reg_p1024;
	logic [2:0]            page_128k;
	logic                  locked;
	logic                  is_p1024;
	logic                  ext_mode;

	assign is_p1024 = (machine_q == pentagon1024);
	// Pentagon extended mode, where the 7FFD lock bit is honoured
	assign ext_mode = page_reg_p1024[`ZX_EFF7_EXT_BIT];

	// ======================================================
	// Paging lock
	// ======================================================
	always_comb begin
		if (machine_q == zx48)
			locked = 1'b1;
		else if (is_p1024)
			locked = page_reg[`ZX_7FFD_LOCK_BIT] & ext_mode;
		else
			locked = page_reg[`ZX_7FFD_LOCK_BIT];
	end

	// Machine type follows the menu only during reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			machine_q <= machine;
	end

	// ======================================================
	// Paging registers
	// ======================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_reg_p1024 <= '0;
			page_128k      <= '0;
		end else if (port_wr.valid) begin
			if (port_wr.port_7ffd && !locked) begin
				page_reg <= port_wr.data;
				// Pentagon 1024 takes the high page bits from D5, D7, D6
				if (is_p1024 && !ext_mode)
					page_128k <= {port_wr.data[5], port_wr.data[7:6]};
			end
			if (port_wr.port_1ffd && !locked)
				page_reg_plus3 <= port_wr.data;
			if (port_wr.port_eff7)
				page_reg_p1024 <= port_wr.data;
			if (port_wr.port_dffd)
				page_128k <= port_wr.data[2:0];
		end
	end

	// ULA port FE
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear          <= 1'b0;
			mic          <= 1'b0;
		end else if (port_wr.valid && port_wr.port_fe) begin
			border_color <= port_wr.data[`ZX_BORDER_W-1:0];
			mic          <= port_wr.data[3];
			ear          <= port_wr.data[4];
		end
	end

	assign paging = '{
		page_reg:       page_reg,
		page_reg_plus3: page_reg_plus3,
		page_reg_p1024: page_reg_p1024,
		page_128k:      page_128k,
		locked:         locked
	};

	assign screen_page = page_reg[`ZX_7FFD_SCREEN_BIT];

	// Decoder keeps the ULA port apart from the paging ports
	a_fe_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(port_wr.port_fe && (port_wr.port_7ffd || port_wr.port_1ffd)));

endmodule

// File: design/z80_cycle_decoder.sv
//==========================================================
// Z80 bus cycle decoder
// Splits the bus into memory commands and single-cycle
// I/O write events with per-machine port decoding
//==========================================================
`timescale 1ns/1ns
`include "zx_mapper_cfg.svh"

module z80_cycle_decoder
	import zx_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  z80_bus_t    bus,
	input  machine_e    machine_q,
	output mem_cmd_t    mem_cmd,
	output port_write_t port_wr
);

	logic                      io_wr;
	logic                      io_wr_q;
	logic [`ZX_CPU_ADDR_W-1:0] a;
	port_write_t               evt_d;
	port_write_t               evt_q;
	logic                      valid_q;

	assign a     = bus.addr;
	assign io_wr = bus.iorq & bus.wr & ~bus.m1;

	// ======================================================
	// Memory side, passed through in the same cycle
	// ======================================================
	always_comb begin
		mem_cmd.rd   = bus.mreq & bus.rd;
		mem_cmd.wr   = bus.mreq & bus.wr;
		mem_cmd.addr = bus.addr;
		mem_cmd.data = bus.data;
	end

	// ======================================================
	// Port classification
	// ======================================================
	// Only odd addresses reach the paging ports, so FE never overlaps them
	always_comb begin
		evt_d.valid     = io_wr & ~io_wr_q;
		evt_d.data      = bus.data;
		evt_d.port_fe   = ~a[0];
		// +3 needs A14 high to tell 7FFD apart from 1FFD
		evt_d.port_7ffd = a[0] & ~a[15] & ~a[1] & (a[14] | (machine_q != plus3));
		evt_d.port_1ffd = a[0] & ~a[15] & ~a[14] & ~a[13] & a[12] & ~a[1] &
			(machine_q == plus3);
		evt_d.port_eff7 = a[0] & a[15] & a[14] & a[13] & ~a[12] & ~a[3] &
			(machine_q == pentagon1024);
		evt_d.port_dffd = (a == 16'hDFFD) & (machine_q == profi1024);
	end

	// Strobe history and the write pulse
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			valid_q <= evt_d.valid;
		end
	end

	// Data and hits, sampled every cycle
	always_ff @(posedge clk_sys) begin
		evt_q <= evt_d;
	end

	assign port_wr = '{
		valid:     valid_q,
		data:      evt_q.data,
		port_7ffd: evt_q.port_7ffd,
		port_1ffd: evt_q.port_1ffd,
		port_eff7: evt_q.port_eff7,
		port_dffd: evt_q.port_dffd,
		port_fe:   evt_q.port_fe
	};

endmodule

// File: design/zx_pkg.sv
//==========================================================
// Spectrum memory mapper types
// Bus strobes, port events, paging state and RAM requests
//==========================================================
`include "zx_mapper_cfg.svh"

package zx_pkg;

	// Machine selected from the memory menu
	typedef enum logic [2:0] {
		zx128        = 3'd0,
		pentagon1024 = 3'd1,
		profi1024    = 3'd2,
		zx48         = 3'd3,
		plus3        = 3'd4
	} machine_e;

	// Z80 bus, strobes active high
	typedef struct packed {
		logic [`ZX_CPU_ADDR_W-1:0] addr;
		logic [`ZX_DATA_W-1:0]     data;
		logic                      mreq;
		logic                      iorq;
		logic                      rd;
		logic                      wr;
		logic                      m1;
	} z80_bus_t;

	// One I/O write event with its port hits
	typedef struct packed {
		logic                  valid;
		logic [`ZX_DATA_W-1:0] data;
		logic                  port_7ffd;
		logic                  port_1ffd;
		logic                  port_eff7;
		logic                  port_dffd;
		logic                  port_fe;
	} port_write_t;

	// Paging registers as seen by the translator
	typedef struct packed {
		logic [`ZX_DATA_W-1:0] page_reg;
		logic [`ZX_DATA_W-1:0] page_reg_plus3;
		logic [`ZX_DATA_W-1:0] page_reg_p1024;
		logic [2:0]            page_128k;
		logic                  locked;
	} paging_t;

	// Memory command straight off the bus
	typedef struct packed {
		logic                      rd;
		logic                      wr;
		logic [`ZX_CPU_ADDR_W-1:0] addr;
		logic [`ZX_DATA_W-1:0]     data;
	} mem_cmd_t;

	// Request to the external RAM
	typedef struct packed {
		logic [`ZX_RAM_ADDR_W-1:0] addr;
		logic [`ZX_DATA_W-1:0]     data;
		logic                      rd;
		logic                      wr;
		logic                      screen_we;
	} mem_req_t;

endpackage

// File: include/zx_mapper_cfg.svh
//==========================================================
// Spectrum memory mapper configuration
// Bus widths, ROM region base and paging port bit positions
//==========================================================
`ifndef ZX_MAPPER_CFG_SVH
`define ZX_MAPPER_CFG_SVH

// Bus and memory widths
`define ZX_RAM_ADDR_W 25
`define ZX_CPU_ADDR_W 16
`define ZX_DATA_W 8
`define ZX_BANK_OFS_W 14
`define ZX_BORDER_W 3

// ROM region marker, placed above the ROM page
`define ZX_ROM_BASE 3'b101

// Video RAM pages
`define ZX_SCREEN_BANK_A 5
`define ZX_SCREEN_BANK_B 7

// Port register bits
`define ZX_7FFD_SCREEN_BIT 3
`define ZX_7FFD_ROM_BIT 4
`define ZX_7FFD_LOCK_BIT 5
`define ZX_1FFD_SPECIAL_BIT 0
`define ZX_1FFD_ROM_BIT 2
`define ZX_EFF7_EXT_BIT 2

`endif
